//--- dv/gbCoreTb.sv
`timescale 1ns/100ps

module gbCoreTb;

	localparam int FifoDepth   = 4;
	localparam int ClockPeriod = 20;
	// Bytes sent over all tests
	localparam int TotalBytes    = 11 + 24 + 78 + 18 + 16;
	localparam int TimeoutCycles = TotalBytes * 40;

	logic                 clock = 1'b0;
	logic                 arstN;
	logic                 byteValid;
	gbUcodePkg::dataT     byteData;
	logic                 byteReady;
	logic                 retireValid;
	gbUcodePkg::retireT   retire;
	logic                 retireReady;

	// Reference model state, A to E at indices 0 to 4
	gbUcodePkg::dataT     mReg [5];
	gbUcodePkg::flagsT    mFlags;
	gbUcodePkg::dataT     byteQ [$];
	gbUcodePkg::retireT   expQ [$];
	logic [31:0]          lfsrState = 32'h2da9efe5;
	int                   longestStall;

	gbCoreTop #(
		.FifoDepth (FifoDepth)
	) gbCoreTop_i
	(
		.clock       (clock),
		.arstN       (arstN),
		.byteValid   (byteValid),
		.byteData    (byteData),
		.byteReady   (byteReady),
		.retireValid (retireValid),
		.retire      (retire),
		.retireReady (retireReady)
	);

	always #(ClockPeriod / 2) clock = ~clock;

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = {lfsrState[30:0],
				lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	task automatic checkValue(input string name, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("Some tests failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Opcode register fields run B, C, D, E, H, L, (HL), A
	function automatic int regIndex(input logic [2:0] field);
		return (field == 3'd7) ? 0 : int'(field) + 1;
	endfunction

	function automatic bit isRegField(input logic [2:0] field);
		return (field == 3'd7) || (field <= 3'd3);
	endfunction

	// Model one instruction, queue its bytes and its expected retire record
	task automatic queueInstr(input gbUcodePkg::opcodeT op, input gbUcodePkg::dataT imm);
		logic [8:0]         res;
		int                 dst;
		int                 src;
		bit                 hasImm;
		gbUcodePkg::retireT rec;
		dst    = regIndex(op[5:3]);
		src    = regIndex(op[2:0]);
		hasImm = 1'b0;
		if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && isRegField(op[5:3]))
		begin
			mReg[dst] = imm;
			hasImm    = 1'b1;
		end
		else if (op[7:6] == 2'b00 && op[2:1] == 2'b10 && isRegField(op[5:3]))
		begin
			// Bit 0 set means DEC, carry untouched
			res       = op[0] ? {1'b0, mReg[dst]} - 9'd1 : {1'b0, mReg[dst]} + 9'd1;
			mReg[dst] = res[7:0];
			mFlags.z  = (res[7:0] == 8'h00);
			mFlags.n  = op[0];
		end
		else if ((op[7:3] == 5'b10000 || op[7:3] == 5'b10010) && isRegField(op[2:0]))
		begin
			res     = op[4] ? {1'b0, mReg[0]} - {1'b0, mReg[src]}
				: {1'b0, mReg[0]} + {1'b0, mReg[src]};
			mReg[0] = res[7:0];
			mFlags  = '{z: (res[7:0] == 8'h00), n: op[4], c: res[8]};
		end
		else if (op == 8'hFE)
		begin
			res    = {1'b0, mReg[0]} - {1'b0, imm};
			mFlags = '{z: (res[7:0] == 8'h00), n: 1'b1, c: res[8]};
			hasImm = 1'b1;
		end
		byteQ.push_back(op);
		if (hasImm)
			byteQ.push_back(imm);
		rec = '{opcode: op, a: mReg[0], b: mReg[1], c: mReg[2], d: mReg[3],
			e: mReg[4], flags: mFlags};
		expQ.push_back(rec);
	endtask

	// Called on a falling edge
	task automatic driveBytes();
		int stallRun;
		while (byteQ.size() > 0)
		begin
			byteValid = 1'b1;
			byteData  = byteQ.pop_front();
			stallRun  = 0;
			while (!byteReady)
			begin
				stallRun++;
				@(negedge clock);
			end
			if (stallRun > longestStall)
				longestStall = stallRun;
			@(negedge clock);
		end
		byteValid = 1'b0;
	endtask

	task automatic collectRetires(input bit gaps);
		gbUcodePkg::retireT exp;
		while (expQ.size() > 0)
		begin
			retireReady = gaps ? (lfsrBits(2) == 32'd0) : 1'b1;
			if (retireValid && retireReady)
			begin
				exp = expQ.pop_front();
				checkValue("retire.opcode", retire.opcode, exp.opcode);
				checkValue("retire.a", retire.a, exp.a);
				checkValue("retire.b", retire.b, exp.b);
				checkValue("retire.c", retire.c, exp.c);
				checkValue("retire.d", retire.d, exp.d);
				checkValue("retire.e", retire.e, exp.e);
				checkValue("retire.flags", retire.flags, exp.flags);
			end
			@(negedge clock);
		end
		retireReady = 1'b1;
	endtask

	task automatic runQueued(input bit gaps);
		@(negedge clock);
		fork
			driveBytes();
			collectRetires(gaps);
		join
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic resetAndLoads();
		queueInstr(8'h00, 8'h00);
		queueInstr(8'h3E, 8'(lfsrBits(8)));
		queueInstr(8'h06, 8'(lfsrBits(8)));
		queueInstr(8'h0E, 8'(lfsrBits(8)));
		queueInstr(8'h16, 8'(lfsrBits(8)));
		queueInstr(8'h1E, 8'(lfsrBits(8)));
		runQueued(1'b0);
	endtask

	task automatic incDecFlags();
		logic [2:0] f;
		// Sets carry so INC and DEC can be seen keeping it
		queueInstr(8'h3E, 8'hF0);
		queueInstr(8'h06, 8'h20);
		queueInstr(8'h80, 8'h00);
		queueInstr(8'h0E, 8'hFF);
		queueInstr(8'h0C, 8'h00);
		queueInstr(8'h16, 8'h00);
		queueInstr(8'h15, 8'h00);
		queueInstr(8'h1E, 8'h01);
		queueInstr(8'h1D, 8'h00);
		for (int k = 0; k < 5; k++)
		begin
			f = (k == 0) ? 3'd7 : 3'(k - 1);
			queueInstr({2'b00, f, 3'b100}, 8'h00);
			queueInstr({2'b00, f, 3'b101}, 8'h00);
		end
		runQueued(1'b0);
	endtask

	task automatic addSubFlags();
		logic [2:0] k;
		queueInstr(8'h3E, 8'h80);
		queueInstr(8'h06, 8'h80);
		queueInstr(8'h80, 8'h00);
		queueInstr(8'h3E, 8'h10);
		queueInstr(8'h0E, 8'h20);
		queueInstr(8'h91, 8'h00);
		queueInstr(8'h97, 8'h00);
		queueInstr(8'h3E, 8'(lfsrBits(8)));
		queueInstr(8'h87, 8'h00);
		for (int i = 0; i < 8; i++)
		begin
			k = 3'(lfsrBits(2));
			queueInstr(8'h3E, 8'(lfsrBits(8)));
			queueInstr({2'b00, k, 3'b110}, 8'(lfsrBits(8)));
			queueInstr({5'b10000, k}, 8'h00);
			queueInstr(8'h3E, 8'(lfsrBits(8)));
			queueInstr({5'b10010, k}, 8'h00);
		end
		runQueued(1'b0);
	endtask

	task automatic compareAndUnknown();
		queueInstr(8'h3E, 8'h42);
		queueInstr(8'hFE, 8'h42);
		queueInstr(8'hFE, 8'h43);
		for (int i = 0; i < 4; i++)
			queueInstr(8'hFE, 8'(lfsrBits(8)));
		// JP, INC H, ADD A,H and HALT all fall to the default flow
		queueInstr(8'hC3, 8'h00);
		queueInstr(8'h24, 8'h00);
		queueInstr(8'h84, 8'h00);
		queueInstr(8'h76, 8'h00);
		runQueued(1'b0);
	endtask

	task automatic retireBackPressure();
		logic [2:0] k;
		logic       sel;
		for (int i = 0; i < 12; i++)
		begin
			k   = 3'(lfsrBits(2));
			sel = 1'(lfsrBits(1));
			case (i % 3)
				0:       queueInstr({2'b00, k, 3'b110}, 8'(lfsrBits(8)));
				1:       queueInstr({2'b00, k, 2'b10, sel}, 8'h00);
				default: queueInstr({3'b100, sel, 1'b0, k}, 8'h00);
			endcase
		end
		longestStall = 0;
		runQueued(1'b1);
		// A hold longer than one cycle means the FIFO was full
		checkValue("byteReady stall cycles >= 2", longestStall >= 2, 1'b1);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		arstN       = 1'b0;
		byteValid   = 1'b0;
		byteData    = '0;
		retireReady = 1'b1;
		mFlags      = '0;
		for (int i = 0; i < 5; i++)
			mReg[i] = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		checkValue("byteReady", byteReady, 1'b1);
		checkValue("retireValid", retireValid, 1'b0);
		resetAndLoads();
		incDecFlags();
		addSubFlags();
		compareAndUnknown();
		retireBackPressure();
		// No extra retire records after the last one
		repeat (4) @(negedge clock);
		checkValue("retireValid", retireValid, 1'b0);
		$display("All tests passed");
		$finish;
	end

	initial
	begin
		#(TimeoutCycles * ClockPeriod);
		$display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
		$display("Some tests failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

//--- dv/gbCore_sva.sv
`timescale 1ns/100ps

module gbCoreSva
(
	input logic               clock,
	input logic               arstN,
	input logic               instrValid,
	input gbUcodePkg::instrT  instr,
	input logic               instrReady,
	input logic               popValid,
	input gbUcodePkg::instrT  popInstr,
	input logic               popReady,
	input logic               retireValid,
	input gbUcodePkg::retireT retire,
	input logic               retireReady
);

	// Fetcher record held until the FIFO takes it
	assert property (@(posedge clock) disable iff (!arstN)
		instrValid && !instrReady |=> instrValid && $stable(instr))
	else
		$error("instrValid or instr changed before the transfer");

	// FIFO head held until the sequencer pops it
	assert property (@(posedge clock) disable iff (!arstN)
		popValid && !popReady |=> popValid && $stable(popInstr))
	else
		$error("popValid or popInstr changed before the transfer");

	assert property (@(posedge clock) disable iff (!arstN)
		retireValid && !retireReady |=> retireValid && $stable(retire))
	else
		$error("retireValid or retire changed before the transfer");

	// Nothing retires while the core is held in reset
	assert property (@(posedge clock) !arstN |-> !retireValid)
	else
		$error("retireValid raised during reset");

endmodule

bind gbCoreTop gbCoreSva coreSva_i
(
	.clock       (clock),
	.arstN       (arstN),
	.instrValid  (instrValid),
	.instr       (instr),
	.instrReady  (instrReady),
	.popValid    (popValid),
	.popInstr    (popInstr),
	.popReady    (popReady),
	.retireValid (retireValid),
	.retire      (retire),
	.retireReady (retireReady)
);

//--- flist.f
verilog/gbUcodePkg.sv
verilog/gbOpFetch.sv
verilog/gbInstrFifo.sv
verilog/gbUcodeLut.sv
verilog/gbUcodeRom.sv
verilog/gbUcodeSequencer.sv
verilog/gbCoreTop.sv
dv/gbCore_sva.sv
dv/gbCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the gbCore testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module gbCoreTb -f flist.f -o gbCoreSim \
	&& ./obj_dir/gbCoreSim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -qx "All tests passed" sim.log \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED"; exit 1; }

//--- verilog/gbCoreTop.sv
`timescale 1ns/100ps

module gbCoreTop
#(
	parameter int FifoDepth = 4
)
(
	input  logic               clock,
	input  logic               arstN,
	input  logic               byteValid,
	input  gbUcodePkg::dataT   byteData,
	output logic               byteReady,
	output logic               retireValid,
	output gbUcodePkg::retireT retire,
	input  logic               retireReady
);

	// Fetcher to FIFO
	logic              instrValid;
	gbUcodePkg::instrT instr;
	logic              instrReady;

	// FIFO to sequencer
	logic              popValid;
	gbUcodePkg::instrT popInstr;
	logic              popReady;

	gbOpFetch opFetch_i
	(
		.clock      (clock),
		.arstN      (arstN),
		.byteValid  (byteValid),
		.byteData   (byteData),
		.byteReady  (byteReady),
		.instrValid (instrValid),
		.instr      (instr),
		.instrReady (instrReady)
	);

	gbInstrFifo #(
		.FifoDepth (FifoDepth)
	) instrFifo_i
	(
		.clock      (clock),
		.arstN      (arstN),
		.instrValid (instrValid),
		.instr      (instr),
		.instrReady (instrReady),
		.popValid   (popValid),
		.popInstr   (popInstr),
		.popReady   (popReady)
	);

	gbUcodeSequencer ucodeSeq_i
	(
		.clock       (clock),
		.arstN       (arstN),
		.popValid    (popValid),
		.popInstr    (popInstr),
		.popReady    (popReady),
		.retireValid (retireValid),
		.retire      (retire),
		.retireReady (retireReady)
	);

endmodule

//--- verilog/gbInstrFifo.sv
`timescale 1ns/100ps

module gbInstrFifo
#(
	parameter int FifoDepth = 4
)
(
	input  logic              clock,
	input  logic              arstN,
	input  logic              instrValid,
	input  gbUcodePkg::instrT instr,
	output logic              instrReady,
	output logic              popValid,
	output gbUcodePkg::instrT popInstr,
	input  logic              popReady
);

	localparam int PtrW = $clog2(FifoDepth);
	localparam int CntW = PtrW + 1;
	localparam logic [CntW-1:0] FullCount = CntW'(FifoDepth);

	gbUcodePkg::instrT mem [FifoDepth];
	logic [PtrW-1:0]   wrPtr;
	logic [PtrW-1:0]   rdPtr;
	logic [CntW-1:0]   count;
	logic              push;
	logic              pop;

	assign instrReady = (count != FullCount);
	assign popValid   = (count != '0);
	assign push       = instrValid && instrReady;
	assign pop        = popValid && popReady;
	assign popInstr   = mem[rdPtr];

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + PtrW'(1);
			if (pop)
				rdPtr <= rdPtr + PtrW'(1);
			case ({push, pop})
				2'b10:   count <= count + CntW'(1);
				2'b01:   count <= count - CntW'(1);
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (push)
			mem[wrPtr] <= instr;
	end

endmodule

//--- verilog/gbOpFetch.sv
`timescale 1ns/100ps

module gbOpFetch
(
	input  logic              clock,
	input  logic              arstN,
	input  logic              byteValid,
	input  gbUcodePkg::dataT  byteData,
	output logic              byteReady,
	output logic              instrValid,
	output gbUcodePkg::instrT instr,
	input  logic              instrReady
);

	typedef enum logic [1:0] {
		FetchOpcode,
		FetchImm,
		FetchHold
	} fetchStateT;

	fetchStateT state;
	logic       byteTaken;
	logic       needsImm;

	// No new bytes while a record waits for the FIFO
	assign byteReady  = (state != FetchHold);
	assign instrValid = (state == FetchHold);
	assign byteTaken  = byteValid && byteReady;

	// Only meaningful while an opcode is expected
	always_comb
	begin
		case (byteData)
			gbUcodePkg::OpcLdAN,
			gbUcodePkg::OpcLdBN,
			gbUcodePkg::OpcLdCN,
			gbUcodePkg::OpcLdDN,
			gbUcodePkg::OpcLdEN,
			gbUcodePkg::OpcCpN:
				needsImm = 1'b1;
			default:
				needsImm = 1'b0;
		endcase
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
			state <= FetchOpcode;
		else
		begin
			case (state)
				FetchOpcode:
					if (byteTaken)
						state <= needsImm ? FetchImm : FetchHold;
				FetchImm:
					if (byteTaken)
						state <= FetchHold;
				default:
					if (instrReady)
						state <= FetchOpcode;
			endcase
		end
	end

	// Record assembly, one-byte opcodes get a zero immediate
	always_ff @(posedge clock)
	begin
		if (byteTaken)
		begin
			if (state == FetchOpcode)
			begin
				instr.opcode <= byteData;
				instr.imm    <= '0;
			end
			else
				instr.imm <= byteData;
		end
	end

endmodule

//--- verilog/gbUcodeLut.sv
`timescale 1ns/100ps

module gbUcodeLut
(
	input  gbUcodePkg::opcodeT  opcode,
	output gbUcodePkg::flowIdxT flowIdx
);

	always_comb
	begin
		case (opcode)
			// NOP
			8'h00:               flowIdx = 8'd1;
			// LD r,n
			gbUcodePkg::OpcLdAN: flowIdx = 8'd2;
			gbUcodePkg::OpcLdBN: flowIdx = 8'd3;
			gbUcodePkg::OpcLdCN: flowIdx = 8'd4;
			gbUcodePkg::OpcLdDN: flowIdx = 8'd5;
			gbUcodePkg::OpcLdEN: flowIdx = 8'd6;
			// INC A, B, C, D, E
			8'h3C:               flowIdx = 8'd7;
			8'h04:               flowIdx = 8'd8;
			8'h0C:               flowIdx = 8'd9;
			8'h14:               flowIdx = 8'd10;
			8'h1C:               flowIdx = 8'd11;
			// DEC A, B, C, D, E
			8'h3D:               flowIdx = 8'd12;
			8'h05:               flowIdx = 8'd13;
			8'h0D:               flowIdx = 8'd14;
			8'h15:               flowIdx = 8'd15;
			8'h1D:               flowIdx = 8'd16;
			// ADD A,r
			8'h87:               flowIdx = 8'd17;
			8'h80:               flowIdx = 8'd20;
			8'h81:               flowIdx = 8'd23;
			8'h82:               flowIdx = 8'd26;
			8'h83:               flowIdx = 8'd29;
			// SUB A,r
			8'h97:               flowIdx = 8'd32;
			8'h90:               flowIdx = 8'd35;
			8'h91:               flowIdx = 8'd38;
			8'h92:               flowIdx = 8'd41;
			8'h93:               flowIdx = 8'd44;
			gbUcodePkg::OpcCpN:  flowIdx = 8'd47;
			// Anything else retires as a no-operation
			default:             flowIdx = 8'd0;
		endcase
	end

endmodule

//--- verilog/gbUcodePkg.sv
package gbUcodePkg;

	//////////////////////////////////////////////////////////////////////
	// Vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [7:0] opcodeT;
	typedef logic [7:0] dataT;
	typedef logic [7:0] flowIdxT;
	typedef logic [2:0] regIdxT;
	typedef logic [1:0] uopCtlT;
	typedef logic [3:0] uopOpT;

	// Registers A through E
	localparam int NumRegs = 5;

	// Register selectors, also register file indices
	localparam regIdxT RegA    = 3'd0;
	localparam regIdxT RegB    = 3'd1;
	localparam regIdxT RegC    = 3'd2;
	localparam regIdxT RegD    = 3'd3;
	localparam regIdxT RegE    = 3'd4;
	localparam regIdxT RegNull = 3'd7;

	// Flow control field
	localparam uopCtlT CtlOp  = 2'd0;
	localparam uopCtlT CtlEof = 2'd1;

	// Micro-op operations
	localparam uopOpT OpNop     = 4'd0;
	localparam uopOpT OpLoadImm = 4'd1;
	localparam uopOpT OpLoadX   = 4'd2;
	localparam uopOpT OpAddX    = 4'd3;
	localparam uopOpT OpSubX    = 4'd4;
	localparam uopOpT OpSubImm  = 4'd5;
	localparam uopOpT OpStoreX  = 4'd6;
	localparam uopOpT OpInc     = 4'd7;
	localparam uopOpT OpDec     = 4'd8;

	// Opcodes that carry an immediate byte
	localparam opcodeT OpcLdAN = 8'h3E;
	localparam opcodeT OpcLdBN = 8'h06;
	localparam opcodeT OpcLdCN = 8'h0E;
	localparam opcodeT OpcLdDN = 8'h16;
	localparam opcodeT OpcLdEN = 8'h1E;
	localparam opcodeT OpcCpN  = 8'hFE;

	//////////////////////////////////////////////////////////////////////
	// Records
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		uopCtlT ctl;
		uopOpT  op;
		regIdxT regSel;
	} uopT;

	typedef struct packed {
		opcodeT opcode;
		dataT   imm;
	} instrT;

	typedef struct packed {
		logic z;
		logic n;
		logic c;
	} flagsT;

	typedef struct packed {
		opcodeT opcode;
		dataT   a;
		dataT   b;
		dataT   c;
		dataT   d;
		dataT   e;
		flagsT  flags;
	} retireT;

endpackage

//--- verilog/gbUcodeRom.sv
`timescale 1ns/100ps

module gbUcodeRom
(
	input  gbUcodePkg::flowIdxT addr,
	output gbUcodePkg::uopT     uop
);

	always_comb
	begin
		case (addr)
			// Default flow and NOP
			0:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpNop, gbUcodePkg::RegNull};
			1:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpNop, gbUcodePkg::RegNull};
			// LD r,n
			2:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpLoadImm, gbUcodePkg::RegA};
			3:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpLoadImm, gbUcodePkg::RegB};
			4:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpLoadImm, gbUcodePkg::RegC};
			5:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpLoadImm, gbUcodePkg::RegD};
			6:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpLoadImm, gbUcodePkg::RegE};
			// INC r
			7:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpInc, gbUcodePkg::RegA};
			8:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpInc, gbUcodePkg::RegB};
			9:  uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpInc, gbUcodePkg::RegC};
			10: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpInc, gbUcodePkg::RegD};
			11: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpInc, gbUcodePkg::RegE};
			// DEC r
			12: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpDec, gbUcodePkg::RegA};
			13: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpDec, gbUcodePkg::RegB};
			14: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpDec, gbUcodePkg::RegC};
			15: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpDec, gbUcodePkg::RegD};
			16: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpDec, gbUcodePkg::RegE};
			// ADD A,r as temp = A, temp += r, A = temp
			17: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			18: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpAddX,   gbUcodePkg::RegA};
			19: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			20: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			21: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpAddX,   gbUcodePkg::RegB};
			22: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			23: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			24: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpAddX,   gbUcodePkg::RegC};
			25: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			26: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			27: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpAddX,   gbUcodePkg::RegD};
			28: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			29: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			30: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpAddX,   gbUcodePkg::RegE};
			31: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			// SUB A,r
			32: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			33: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpSubX,   gbUcodePkg::RegA};
			34: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			35: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			36: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpSubX,   gbUcodePkg::RegB};
			37: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			38: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			39: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpSubX,   gbUcodePkg::RegC};
			40: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			41: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			42: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpSubX,   gbUcodePkg::RegD};
			43: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			44: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			45: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpSubX,   gbUcodePkg::RegE};
			46: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpStoreX, gbUcodePkg::RegA};
			// CP n, the result stays in temp so A is untouched
			47: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpLoadX,  gbUcodePkg::RegA};
			48: uop = '{gbUcodePkg::CtlOp,  gbUcodePkg::OpSubImm, gbUcodePkg::RegNull};
			49: uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpNop,    gbUcodePkg::RegNull};
			default:
				uop = '{gbUcodePkg::CtlEof, gbUcodePkg::OpNop, gbUcodePkg::RegNull};
		endcase
	end

endmodule

//--- verilog/gbUcodeSequencer.sv
`timescale 1ns/100ps

module gbUcodeSequencer
(
	input  logic               clock,
	input  logic               arstN,
	input  logic               popValid,
	input  gbUcodePkg::instrT  popInstr,
	output logic               popReady,
	output logic               retireValid,
	output gbUcodePkg::retireT retire,
	input  logic               retireReady
);

	typedef enum logic [1:0] {
		SeqIdle,
		SeqRun,
		SeqRetire
	} seqStateT;

	seqStateT            state;
	gbUcodePkg::flowIdxT upc;
	gbUcodePkg::flowIdxT lutIdx;
	gbUcodePkg::uopT     uop;
	gbUcodePkg::instrT   cur;
	gbUcodePkg::dataT    rf [gbUcodePkg::NumRegs];
	gbUcodePkg::flagsT   flags;
	gbUcodePkg::flagsT   aluFlags;
	gbUcodePkg::dataT    regVal;
	gbUcodePkg::dataT    regWrData;
	logic [8:0]          temp;
	logic [8:0]          aluRes;
	logic                regWrEn;
	logic                tempWr;
	logic                pop;
	logic                execute;

	gbUcodeLut ucodeLut_i
	(
		.opcode  (popInstr.opcode),
		.flowIdx (lutIdx)
	);

	gbUcodeRom ucodeRom_i
	(
		.addr (upc),
		.uop  (uop)
	);

	assign popReady    = (state == SeqIdle);
	assign pop         = popValid && popReady;
	assign execute     = (state == SeqRun);
	assign retireValid = (state == SeqRetire);

	// State stays frozen while the retire record waits
	assign retire = '{
		opcode: cur.opcode,
		a:      rf[gbUcodePkg::RegA],
		b:      rf[gbUcodePkg::RegB],
		c:      rf[gbUcodePkg::RegC],
		d:      rf[gbUcodePkg::RegD],
		e:      rf[gbUcodePkg::RegE],
		flags:  flags
	};

	// RegNull reads as zero
	assign regVal = (uop.regSel < gbUcodePkg::NumRegs) ? rf[uop.regSel] : '0;

	//////////////////////////////////////////////////////////////////////
	// Micro-op datapath
	//////////////////////////////////////////////////////////////////////

	// Bit 8 of the result is the carry, or the borrow on subtract
	always_comb
	begin
		aluRes   = {1'b0, regVal};
		aluFlags = flags;
		case (uop.op)
			gbUcodePkg::OpAddX:
			begin
				aluRes     = {1'b0, temp[7:0]} + {1'b0, regVal};
				aluFlags.z = (aluRes[7:0] == '0);
				aluFlags.n = 1'b0;
				aluFlags.c = aluRes[8];
			end
			gbUcodePkg::OpSubX:
			begin
				aluRes     = {1'b0, temp[7:0]} - {1'b0, regVal};
				aluFlags.z = (aluRes[7:0] == '0);
				aluFlags.n = 1'b1;
				aluFlags.c = aluRes[8];
			end
			gbUcodePkg::OpSubImm:
			begin
				aluRes     = {1'b0, temp[7:0]} - {1'b0, cur.imm};
				aluFlags.z = (aluRes[7:0] == '0);
				aluFlags.n = 1'b1;
				aluFlags.c = aluRes[8];
			end
			// INC and DEC keep the carry
			gbUcodePkg::OpInc:
			begin
				aluRes     = {1'b0, regVal} + 9'd1;
				aluFlags.z = (aluRes[7:0] == '0);
				aluFlags.n = 1'b0;
			end
			gbUcodePkg::OpDec:
			begin
				aluRes     = {1'b0, regVal} - 9'd1;
				aluFlags.z = (aluRes[7:0] == '0);
				aluFlags.n = 1'b1;
			end
			default:
				aluFlags = flags;
		endcase
	end

	// Write-back selection
	always_comb
	begin
		regWrEn   = 1'b0;
		tempWr    = 1'b0;
		regWrData = aluRes[7:0];
		case (uop.op)
			gbUcodePkg::OpLoadImm:
			begin
				regWrEn   = 1'b1;
				regWrData = cur.imm;
			end
			gbUcodePkg::OpStoreX:
			begin
				regWrEn   = 1'b1;
				regWrData = temp[7:0];
			end
			gbUcodePkg::OpInc,
			gbUcodePkg::OpDec:
				regWrEn = 1'b1;
			gbUcodePkg::OpLoadX,
			gbUcodePkg::OpAddX,
			gbUcodePkg::OpSubX,
			gbUcodePkg::OpSubImm:
				tempWr = 1'b1;
			default:
				regWrEn = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Sequencing and architectural state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= SeqIdle;
			upc   <= '0;
			flags <= '0;
			for (int i = 0; i < gbUcodePkg::NumRegs; i++)
				rf[i] <= '0;
		end
		else
		begin
			case (state)
				SeqIdle:
					if (pop)
					begin
						upc   <= lutIdx;
						state <= SeqRun;
					end
				SeqRun:
				begin
					upc   <= upc + 8'd1;
					flags <= aluFlags;
					if (regWrEn && (uop.regSel < gbUcodePkg::NumRegs))
						rf[uop.regSel] <= regWrData;
					if (uop.ctl == gbUcodePkg::CtlEof)
						state <= SeqRetire;
				end
				default:
					if (retireReady)
						state <= SeqIdle;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (pop)
			cur <= popInstr;
		if (execute && tempWr)
			temp <= aluRes;
	end

endmodule
